/* design/pwm_pkg.sv */
/*
  Shared sizes and channel structs for the PWM bank.
  channels may be set anywhere from 1 to 255.
  period must not exceed 2**pwm_width, since the counter is pwm_width bits.
*/

package pwm_pkg;

  // ============================================================
  // sizes
  // ============================================================
  localparam int pwm_width      = 9;
  localparam int period         = 512;
  localparam int channels       = 8;
  localparam int addsub_latency = 2;   // registers per add/sub stage.

  // one add/sub stage costs its operand register plus the adder depth.
  localparam int stage_depth = addsub_latency + 1;

  // channel counters must reach channels itself, not only channels-1.
  localparam int cnt_w = $clog2(channels + 1);

  typedef logic [cnt_w-1:0] chan_cnt_t;

  localparam chan_cnt_t chan_total = chan_cnt_t'(channels);

  localparam logic [pwm_width-1:0] cnt_last = pwm_width'(period - 1);

  // ============================================================
  // channel words
  // ============================================================

  // host setting for one channel.
  typedef struct packed {
    logic [pwm_width-1:0] duty;
    logic [pwm_width-1:0] phase;
  } chan_setting_t;

  // output window of one channel, in counter steps.
  typedef struct packed {
    logic [pwm_width-1:0] rise;
    logic [pwm_width-1:0] fall;
  } chan_edges_t;

endpackage

/* design/pwm_preconditioner.sv */
/*
  Settings must arrive on consecutive cycles, channel 0 with din_valid.
  A din_valid while busy or while a frame is in flight is dropped.
  The working buffer holds still from frame_done until the next accepted frame.
*/

`timescale 1ns/1ps

module pwm_preconditioner (
  input  logic                    CLK,
  input  logic                    arst_n,
  input  logic                    din_valid,
  input  pwm_pkg::chan_setting_t  setting,
  input  logic                    busy,
  output pwm_pkg::chan_edges_t    edges [pwm_pkg::channels],
  output logic                    frame_done
);

  typedef logic signed [pwm_pkg::pwm_width+1:0] word_t;

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_done
  } state_t;

  // one slot per add/sub stage.
  typedef enum int {
    add_phase,   // period - phase.
    add_half,    // half_hi = half_lo + duty[0].
    add_rise,
    add_fall,
    add_frise,
    add_ffall,
    add_count
  } slot_t;

  state_t             state;
  pwm_pkg::chan_cnt_t in_cnt;    // channels issued into the pipeline.
  pwm_pkg::chan_cnt_t set_cnt;   // channels written to the buffer.
  logic               issue;
  logic [3*pwm_pkg::stage_depth-1:0] vld;

  word_t period_w;
  word_t op_a    [add_count];
  word_t op_b    [add_count];
  logic  op_sub  [add_count];
  word_t sum     [add_count];
  word_t half_lo [pwm_pkg::stage_depth];

  pwm_pkg::chan_edges_t work [pwm_pkg::channels];
  pwm_pkg::chan_edges_t folded;

  assign period_w = word_t'(pwm_pkg::period);

  // channel 0 enters with din_valid, the rest follow back to back.
  assign issue = (state == st_idle && din_valid && !busy) ||
                 (state == st_run && in_cnt != pwm_pkg::chan_total);

  // ============================================================
  // add/sub pipelines
  // ============================================================
  for (genvar i = 0; i < add_count; i++) begin : g_addsub
    word_t pipe [pwm_pkg::addsub_latency];

    always_ff @(posedge CLK) begin
      pipe[0] <= op_sub[i] ? op_a[i] - op_b[i] : op_a[i] + op_b[i];
      for (int j = 1; j < pwm_pkg::addsub_latency; j++) begin
        pipe[j] <= pipe[j-1];
      end
    end

    assign sum[i] = pipe[pwm_pkg::addsub_latency-1];
  end

  // ============================================================
  // operand stages
  // ============================================================
  always_ff @(posedge CLK) begin
    // stage 1.
    op_a[add_phase]   <= period_w;
    op_b[add_phase]   <= word_t'(setting.phase);
    op_sub[add_phase] <= 1'b1;
    op_a[add_half]    <= word_t'(setting.duty >> 1);
    op_b[add_half]    <= word_t'(setting.duty[0]);
    op_sub[add_half]  <= 1'b0;

    // half_lo rides along until stage 2 picks it up.
    half_lo[0] <= word_t'(setting.duty >> 1);
    for (int j = 1; j < pwm_pkg::stage_depth; j++) begin
      half_lo[j] <= half_lo[j-1];
    end

    // stage 2, raw edges.
    op_a[add_rise]   <= sum[add_phase];
    op_b[add_rise]   <= half_lo[pwm_pkg::stage_depth-1];
    op_sub[add_rise] <= 1'b1;
    op_a[add_fall]   <= sum[add_phase];
    op_b[add_fall]   <= sum[add_half];
    op_sub[add_fall] <= 1'b0;

    // stage 3, fold back into one period.
    op_a[add_frise] <= sum[add_rise];
    if (sum[add_rise][pwm_pkg::pwm_width+1]) begin
      op_b[add_frise]   <= period_w;   // negative, add a period.
      op_sub[add_frise] <= 1'b0;
    end else if (sum[add_rise] >= period_w) begin
      op_b[add_frise]   <= period_w;
      op_sub[add_frise] <= 1'b1;
    end else begin
      op_b[add_frise]   <= '0;
      op_sub[add_frise] <= 1'b0;
    end

    // fall never goes negative, only past the end.
    op_a[add_ffall]   <= sum[add_fall];
    op_b[add_ffall]   <= (sum[add_fall] >= period_w) ? period_w : '0;
    op_sub[add_ffall] <= 1'b1;
  end

  assign folded.rise = sum[add_frise][pwm_pkg::pwm_width-1:0];
  assign folded.fall = sum[add_ffall][pwm_pkg::pwm_width-1:0];

  // ============================================================
  // working buffer
  // ============================================================
  for (genvar c = 0; c < pwm_pkg::channels; c++) begin : g_work
    always_ff @(posedge CLK) begin
      if (vld[3*pwm_pkg::stage_depth-1] && set_cnt == pwm_pkg::chan_cnt_t'(c)) begin
        work[c] <= folded;
      end
    end
  end

  assign edges = work;

  // control.
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state      <= st_idle;
      in_cnt     <= '0;
      set_cnt    <= '0;
      vld        <= '0;
      frame_done <= 1'b0;
    end else begin
      vld        <= {vld[3*pwm_pkg::stage_depth-2:0], issue};
      frame_done <= 1'b0;
      if (vld[3*pwm_pkg::stage_depth-1]) begin
        set_cnt <= set_cnt + 1'b1;
      end
      case (state)
        st_idle: begin
          if (issue) begin
            in_cnt <= pwm_pkg::chan_cnt_t'(1);
            state  <= st_run;
          end
        end
        st_run: begin
          if (in_cnt != pwm_pkg::chan_total) begin
            in_cnt <= in_cnt + 1'b1;
          end
          if (set_cnt == pwm_pkg::chan_total) begin
            state <= st_done;   // pipeline has drained.
          end
        end
        st_done: begin
          frame_done <= 1'b1;
          set_cnt    <= '0;
          state      <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

/* design/pwm_edge_table.sv */
/*
  Holds the edges the bank is running on.
  A finished frame waits here and is copied in only on wrap,
  so each period runs on one frame throughout.
*/

`timescale 1ns/1ps

module pwm_edge_table (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic                 din_valid,
  input  logic                 frame_done,
  input  pwm_pkg::chan_edges_t edges_in [pwm_pkg::channels],
  input  logic                 wrap,
  output logic                 busy,
  output pwm_pkg::chan_edges_t edges_out [pwm_pkg::channels]
);

  pwm_pkg::chan_edges_t active [pwm_pkg::channels];
  logic                 pending;
  logic                 commit;

  // a frame finishing on the wrap cycle itself goes in at once.
  assign commit = wrap && (pending || frame_done);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      busy    <= 1'b0;
      pending <= 1'b0;
      for (int i = 0; i < pwm_pkg::channels; i++) begin
        active[i] <= '0;   // all windows empty, outputs low.
      end
    end else begin
      if (din_valid && !busy) begin
        busy <= 1'b1;
      end
      if (frame_done) begin
        pending <= 1'b1;
      end
      if (commit) begin
        active  <= edges_in;
        pending <= 1'b0;
        busy    <= 1'b0;   // next frame may start.
      end
    end
  end

  assign edges_out = active;

endmodule

/* design/pwm_bank.sv */
/*
  Free-running period counter shared by every channel.
  pwm_out and sync lag the counter by one cycle.
  sync marks the cycle where pwm_out shows counter value 0.
*/

`timescale 1ns/1ps

module pwm_bank (
  input  logic                         CLK,
  input  logic                         arst_n,
  input  pwm_pkg::chan_edges_t         edges [pwm_pkg::channels],
  output logic                         wrap,
  output logic [pwm_pkg::channels-1:0] pwm_out,
  output logic                         sync
);

  logic [pwm_pkg::pwm_width-1:0] cnt;
  logic [pwm_pkg::channels-1:0]  hit;

  assign wrap = (cnt == pwm_pkg::cnt_last);   // last step of the period.

  // ============================================================
  // window compare
  // ============================================================
  always_comb begin
    for (int i = 0; i < pwm_pkg::channels; i++) begin
      if (edges[i].rise <= edges[i].fall) begin
        // plain window, empty when rise equals fall.
        hit[i] = (cnt >= edges[i].rise) && (cnt < edges[i].fall);
      end else begin
        // wraps across the period end.
        hit[i] = (cnt >= edges[i].rise) || (cnt < edges[i].fall);
      end
    end
  end

  // ============================================================
  // counter and outputs
  // ============================================================
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cnt     <= '0;
      pwm_out <= '0;
      sync    <= 1'b0;
    end else begin
      cnt     <= wrap ? '0 : cnt + 1'b1;
      pwm_out <= hit;
      sync    <= (cnt == '0);
    end
  end

endmodule

/* design/pwm_top.sv */
/*
  PWM subsystem, decode, edge table and bank in a row.
  A frame takes channels + 3*(pwm_pkg::addsub_latency+1) + 2 cycles to decode,
  then waits for the next period boundary before it drives the outputs.
*/

`timescale 1ns/1ps

module pwm_top (
  input  logic                         CLK,
  input  logic                         arst_n,
  input  logic                         din_valid,
  input  pwm_pkg::chan_setting_t       setting,
  output logic [pwm_pkg::channels-1:0] pwm_out,
  output logic                         sync
);

  pwm_pkg::chan_edges_t edges_work   [pwm_pkg::channels];
  pwm_pkg::chan_edges_t edges_active [pwm_pkg::channels];
  logic                 frame_done;
  logic                 busy;
  logic                 wrap;

  pwm_preconditioner i_pwm_preconditioner (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .din_valid  (din_valid),
    .setting    (setting),
    .busy       (busy),
    .edges      (edges_work),
    .frame_done (frame_done)
  );

  pwm_edge_table i_pwm_edge_table (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .din_valid  (din_valid),
    .frame_done (frame_done),
    .edges_in   (edges_work),
    .wrap       (wrap),
    .busy       (busy),
    .edges_out  (edges_active)
  );

  pwm_bank i_pwm_bank (
    .CLK     (CLK),
    .arst_n  (arst_n),
    .edges   (edges_active),
    .wrap    (wrap),
    .pwm_out (pwm_out),
    .sync    (sync)
  );

endmodule

/* dv/pwm_tb.sv */
/*
  Self-checking testbench for pwm_top, random settings from seed 36.
  Frames are sent mid-period with margin, so each commits at the next sync.
  Outputs are sampled on the falling clock edge, inputs change 1 ns after rise.
  Corner frames index their tables with the channel number modulo 8.
*/

`timescale 1ns/1ps

module pwm_tb;

  localparam int seed_init     = 36;
  localparam int random_frames = 10;
  localparam int clk_half      = 4;
  localparam int drive_delay   = 1;
  localparam int max_err_lines = 10;   // per test, the rest are only counted.

  // din_valid to frame_done, in cycles.
  localparam int frame_latency = pwm_pkg::channels + 3 * (pwm_pkg::addsub_latency + 1) + 2;
  localparam int late_step     = pwm_pkg::period - frame_latency - 24;
  localparam int timeout_cycles = 16 * 4 * pwm_pkg::period + 1000;

  localparam int corner_duty  [2][8] = '{'{0, 511, 511, 0, 100, 100, 1, 510},
                                         '{1, 511, 256, 256, 0, 300, 2, 509}};
  localparam int corner_phase [2][8] = '{'{0, 0, 511, 511, 0, 256, 511, 255},
                                         '{0, 256, 0, 511, 128, 100, 300, 1}};

  logic                         CLK = 1'b0;
  logic                         arst_n;
  logic                         din_valid;
  pwm_pkg::chan_setting_t       setting;
  logic [pwm_pkg::channels-1:0] pwm_out;
  logic                         sync;

  // model of the committed edges.
  pwm_pkg::chan_edges_t   model_act  [pwm_pkg::channels];
  pwm_pkg::chan_edges_t   model_next [pwm_pkg::channels];
  int                     act_duty   [pwm_pkg::channels];
  int                     next_duty  [pwm_pkg::channels];
  int                     high_cnt   [pwm_pkg::channels];
  pwm_pkg::chan_setting_t frame_buf  [pwm_pkg::channels];
  bit                     swap_pending;
  bit                     sync_seen;
  int                     step;          // counter value shown on pwm_out.
  logic [pwm_pkg::channels-1:0] exp_out;
  bit                     cover_on;
  bit                     saw_wrap;
  bit                     saw_plain;

  int    seed;
  int    cycle_cnt;
  string test_name;
  int    test_errs;
  int    total_errs;
  int    pass_cnt;
  int    fail_cnt;

  pwm_top i_pwm_top (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .din_valid (din_valid),
    .setting   (setting),
    .pwm_out   (pwm_out),
    .sync      (sync)
  );

  always #clk_half CLK = ~CLK;

  // ============================================================
  // reference model
  // ============================================================
  function automatic pwm_pkg::chan_edges_t edges_of(pwm_pkg::chan_setting_t s);
    pwm_pkg::chan_edges_t e;
    int half_lo;
    int half_hi;
    int r;
    int f;
    half_lo = int'(s.duty) / 2;
    half_hi = int'(s.duty) - half_lo;
    // two periods up front keep the remainder positive.
    r = (2 * pwm_pkg::period - int'(s.phase) - half_lo) % pwm_pkg::period;
    f = (2 * pwm_pkg::period - int'(s.phase) + half_hi) % pwm_pkg::period;
    e.rise = r[pwm_pkg::pwm_width-1:0];
    e.fall = f[pwm_pkg::pwm_width-1:0];
    return e;
  endfunction

  function automatic bit in_window(pwm_pkg::chan_edges_t e, int t);
    if (e.rise <= e.fall) begin
      return (t >= e.rise) && (t < e.fall);
    end
    return (t >= e.rise) || (t < e.fall);   // wrapped window.
  endfunction

  function automatic logic [pwm_pkg::channels-1:0] expected_out(int t);
    logic [pwm_pkg::channels-1:0] v;
    int ch;
    for (ch = 0; ch < pwm_pkg::channels; ch++) begin
      v[ch] = in_window(model_act[ch], t);
    end
    return v;
  endfunction

  task automatic log_error(input string line);
    if (test_errs < max_err_lines) begin
      $display("%s", line);
    end
    test_errs++;
    total_errs++;
  endtask

  // ============================================================
  // output monitor
  // ============================================================
  always @(negedge CLK) begin : monitor
    int ch;
    if (sync) begin
      if (sync_seen) begin
        assert (step == pwm_pkg::period - 1) else begin
          log_error($sformatf("ERROR %s: sync spacing expected %0d actual %0d",
                              test_name, pwm_pkg::period, step + 1));
        end
        for (ch = 0; ch < pwm_pkg::channels; ch++) begin
          assert (high_cnt[ch] == act_duty[ch]) else begin
            log_error($sformatf("ERROR %s: channel %0d high steps expected %0d actual %0d",
                                test_name, ch, act_duty[ch], high_cnt[ch]));
          end
        end
      end
      for (ch = 0; ch < pwm_pkg::channels; ch++) begin
        high_cnt[ch] = 0;
      end
      if (swap_pending) begin   // new frame runs from this sync on.
        for (ch = 0; ch < pwm_pkg::channels; ch++) begin
          model_act[ch] = model_next[ch];
          act_duty[ch]  = next_duty[ch];
        end
        swap_pending = 1'b0;
      end
      step      = 0;
      sync_seen = 1'b1;
    end else if (sync_seen) begin
      step++;
      assert (step < pwm_pkg::period) else begin
        log_error($sformatf("%s: sync did not arrive within %0d cycles",
                            test_name, pwm_pkg::period));
      end
    end
    exp_out = sync_seen ? expected_out(step) : '0;
    assert (pwm_out === exp_out) else begin
      log_error($sformatf("ERROR %s: pwm_out at step %0d expected %h actual %h",
                          test_name, step, exp_out, pwm_out));
    end
    // window kind as the outputs show it, judged on the last step.
    if (cover_on && step == pwm_pkg::period - 1) begin
      for (ch = 0; ch < pwm_pkg::channels; ch++) begin
        if (pwm_out[ch] === 1'b1) begin
          saw_wrap = 1'b1;   // a plain window always ends before the last step.
        end else if (high_cnt[ch] != 0) begin
          saw_plain = 1'b1;
        end
      end
    end
    for (ch = 0; ch < pwm_pkg::channels; ch++) begin
      if (pwm_out[ch] === 1'b1) high_cnt[ch]++;
    end
  end

  // ============================================================
  // stimulus
  // ============================================================
  task automatic wait_step(input int s);
    do begin
      @(negedge CLK);
      #1;
    end while (!(sync_seen && step == s));
  endtask

  task automatic wait_syncs(input int n);
    repeat (n) begin
      do begin
        @(negedge CLK);
        #1;
      end while (sync !== 1'b1);
    end
  endtask

  // one setting per cycle, channel 0 along with din_valid.
  task automatic drive_frame(input bit accepted);
    int ch;
    @(posedge CLK);
    #drive_delay;
    din_valid = 1'b1;
    setting   = frame_buf[0];
    if (accepted) begin
      for (ch = 0; ch < pwm_pkg::channels; ch++) begin
        model_next[ch] = edges_of(frame_buf[ch]);
        next_duty[ch]  = int'(frame_buf[ch].duty);
      end
      swap_pending = 1'b1;
    end
    for (ch = 1; ch < pwm_pkg::channels; ch++) begin
      @(posedge CLK);
      #drive_delay;
      din_valid = 1'b0;
      setting   = frame_buf[ch];
    end
    @(posedge CLK);
    #drive_delay;
    din_valid = 1'b0;
    setting   = '0;
  endtask

  task automatic fill_random();
    logic [31:0] rnd;
    int ch;
    for (ch = 0; ch < pwm_pkg::channels; ch++) begin
      rnd = $random(seed);
      frame_buf[ch].duty  = rnd[pwm_pkg::pwm_width-1:0];
      frame_buf[ch].phase = rnd[pwm_pkg::pwm_width+15:16];
    end
  endtask

  task automatic fill_corner(input int variant);
    int d;
    int p;
    int ch;
    for (ch = 0; ch < pwm_pkg::channels; ch++) begin
      d = corner_duty[variant][ch % 8];
      p = corner_phase[variant][ch % 8];
      frame_buf[ch].duty  = d[pwm_pkg::pwm_width-1:0];
      frame_buf[ch].phase = p[pwm_pkg::pwm_width-1:0];
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    if (test_errs == 0) begin
      pass_cnt++;
      $display("%s: pass", test_name);
    end else begin
      fail_cnt++;
      $display("%s: fail with %0d errors", test_name, test_errs);
    end
  endtask

  // ============================================================
  // test sequence
  // ============================================================
  initial begin : sequencer
    logic [31:0] rnd;
    int f;
    int v;
    seed         = seed_init;
    arst_n       = 1'b0;
    din_valid    = 1'b0;
    setting      = '0;
    swap_pending = 1'b0;
    sync_seen    = 1'b0;
    step         = 0;
    cover_on     = 1'b0;
    saw_wrap     = 1'b0;
    saw_plain    = 1'b0;
    total_errs   = 0;
    pass_cnt     = 0;
    fail_cnt     = 0;
    for (f = 0; f < pwm_pkg::channels; f++) begin
      model_act[f] = '0;   // empty windows, as after reset.
      act_duty[f]  = 0;
      high_cnt[f]  = 0;
    end

    start_test("reset_state");
    repeat (8) @(posedge CLK);
    #drive_delay;
    arst_n = 1'b1;
    wait_syncs(3);
    finish_test();

    start_test("random_frames");
    for (f = 0; f < random_frames; f++) begin
      fill_random();
      rnd = $random(seed);
      wait_step(16 + int'(rnd[15:0]) % (late_step - 16));
      drive_frame(1'b1);
      wait_syncs(3);
    end
    finish_test();

    start_test("corner_settings");
    for (v = 0; v < 2; v++) begin
      fill_corner(v);
      wait_step(32);
      drive_frame(1'b1);
      wait_syncs(1);
      cover_on = 1'b1;   // corner edges are live from this sync on.
      wait_syncs(2);
    end
    cover_on = 1'b0;
    assert (saw_wrap && saw_plain) else begin
      log_error("corner_settings: the outputs did not show both wrapped and plain windows");
    end
    finish_test();

    // the monitor holds the old frame until the sync after din_valid.
    start_test("atomic_commit");
    fill_random();
    wait_step(250);
    drive_frame(1'b1);
    wait_syncs(3);
    fill_random();
    wait_step(late_step);
    drive_frame(1'b1);
    wait_syncs(3);
    finish_test();

    start_test("dropped_frame");
    fill_random();
    wait_step(16);
    drive_frame(1'b1);
    fill_random();
    drive_frame(1'b0);          // decode still running.
    repeat (40) @(posedge CLK);
    fill_random();
    drive_frame(1'b0);          // decoded, waiting for commit.
    wait_syncs(3);
    finish_test();

    $display("tests passed: %0d, tests failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

endmodule

/* filelist.f */
design/pwm_pkg.sv
design/pwm_preconditioner.sv
design/pwm_edge_table.sv
design/pwm_bank.sv
design/pwm_top.sv
dv/pwm_tb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the PWM testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pwm_tb \
  -f filelist.f -o pwm_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/pwm_sim | tee /dev/stderr | grep -qx "TEST OK" \
  && { echo "simulation passed"; exit 0; } \
  || { echo "simulation failed"; exit 1; }
